// File: tb.f
src/pattern_pkg.sv
src/reg_map_pkg.sv
src/pattern_ctl_if.sv
src/pattern_regs.sv
src/pattern_loop.sv
src/pattern_sequencer.sv
src/pattern_ctrl.sv
sim/tb_clock_gen.sv
sim/tb_pattern_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the pattern generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pattern_ctrl -f tb.f -o sim_tb \
   || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1

// File: sim/tb_pattern_ctrl.sv
// Pattern generator testbench
// Register access, queue reference model of both FIFOs, output stream checks
`timescale 1ns/100ps

module tb_pattern_ctrl;
   import pattern_pkg::*;
   import reg_map_pkg::*;

   localparam int pattern_width = 64;
   localparam int fifo_depth    = 16;
   localparam int words_c       = pattern_width / 32;

   // Byte addresses of the register map
   localparam data_t ctl_addr_c      = data_t'(reg_fifo_ctl_c * 4);
   localparam data_t start_addr_c    = data_t'(reg_start_c * 4);
   localparam data_t f0_cnt_addr_c   = data_t'(reg_f0_count_c * 4);
   localparam data_t f1_cnt_addr_c   = data_t'(reg_f1_count_c * 4);
   localparam data_t input_addr_c    = data_t'(reg_input_base_c * 4);
   localparam data_t unmapped_addr_c = 32'h20;

   // Run limit from the register ops and the streamed items
   // Op cycles cover the clear wait
   // Item cycles allow for random stalls
   localparam int reg_ops_c        = 50;
   localparam int op_cycles_c      = 12;
   localparam int stream_items_c   = 64;
   localparam int item_cycles_c    = 6;
   localparam int quiet_cycles_c   = 24;
   localparam int timeout_cycles_c = 16 + reg_ops_c * op_cycles_c +
                                     stream_items_c * item_cycles_c + 2 * quiet_cycles_c;

   logic                     clk;
   logic                     resetn;
   data_t                    wr_addr;
   data_t                    wr_data;
   logic                     wr_strobe;
   resp_t                    wr_resp;
   logic                     wr_idle;
   data_t                    rd_addr;
   logic                     rd_strobe;
   data_t                    rd_data;
   resp_t                    rd_resp;
   logic                     rd_idle;
   logic [pattern_width-1:0] out_data;
   logic                     out_valid;
   logic                     out_ready;

   // Reference model with one queue per FIFO in output order
   logic [pattern_width-1:0] q0 [$];
   logic [pattern_width-1:0] q1 [$];
   fifo_sel_t                model_on_deck = sel_none_c;
   fifo_sel_t                model_active  = sel_none_c;
   int                       model_remaining = 0;
   int                       accepted    = 0;
   int                       f1_items    = 0;
   int                       error_count = 0;
   int                       check_count = 0;
   int                       cycle_count = 0;
   logic [31:0]              lfsr_state  = 32'd75820;

   tb_clock_gen #(.period_ns(8), .reset_cycles(16)) clock_gen_inst (
      .clk   (clk),
      .resetn(resetn)
   );

   pattern_ctrl #(
      .pattern_width(pattern_width),
      .fifo_depth   (fifo_depth)
   ) pattern_ctrl_inst (
      .clk      (clk),
      .resetn   (resetn),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_strobe(wr_strobe),
      .wr_resp  (wr_resp),
      .wr_idle  (wr_idle),
      .rd_addr  (rd_addr),
      .rd_strobe(rd_strobe),
      .rd_data  (rd_data),
      .rd_resp  (rd_resp),
      .rd_idle  (rd_idle),
      .out_data (out_data),
      .out_valid(out_valid),
      .out_ready(out_ready)
   );

   // ========================================
   // Random source and reference model
   // ========================================
   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // A start value holds only with one bit set and a FIFO that has items
   function automatic fifo_sel_t start_rule(input data_t value);
      if (value[1:0] == sel_f0_c && q0.size() != 0) begin
         return sel_f0_c;
      end
      if (value[1:0] == sel_f1_c && q1.size() != 0) begin
         return sel_f1_c;
      end
      return sel_none_c;
   endfunction

   // Frame length is the item count of the FIFO taken
   function automatic void begin_frame();
      if (model_on_deck == sel_f0_c && q0.size() != 0) begin
         model_active    = sel_f0_c;
         model_remaining = q0.size();
      end else if (model_on_deck == sel_f1_c && q1.size() != 0) begin
         model_active    = sel_f1_c;
         model_remaining = q1.size();
      end else begin
         model_active    = sel_none_c;
         model_remaining = 0;
      end
   endfunction

   // Next expected item
   // Each item sent goes back to the tail of its FIFO
   function automatic logic [pattern_width-1:0] predict_next_item(output bit known);
      logic [pattern_width-1:0] item;
      item  = '0;
      known = 1'b1;
      if (model_active == sel_none_c) begin
         begin_frame();
      end
      case (model_active)
         sel_f0_c: begin
            item = q0.pop_front();
            q0.push_back(item);
         end
         sel_f1_c: begin
            item = q1.pop_front();
            q1.push_back(item);
            f1_items++;
         end
         default: known = 1'b0;
      endcase
      if (known) begin
         model_remaining--;
         // Frame boundary takes whatever is on deck now
         if (model_remaining == 0) begin
            begin_frame();
         end
      end
      return item;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
      end
   endtask

   // ========================================
   // Register access
   // ========================================
   task automatic reg_write(input data_t addr, input data_t data, output resp_t resp);
      while (!wr_idle) @(posedge clk);
      wr_addr   <= addr;
      wr_data   <= data;
      wr_strobe <= 1'b1;
      @(posedge clk);
      wr_strobe <= 1'b0;
      // On deck changes at this edge
      // A frame ending here still sees the old value
      if (addr == start_addr_c) begin
         model_on_deck <= start_rule(data);
      end
      @(posedge clk);
      resp = wr_resp;
   endtask

   task automatic reg_read(input data_t addr, output data_t data, output resp_t resp);
      while (!rd_idle) @(posedge clk);
      rd_addr   <= addr;
      rd_strobe <= 1'b1;
      @(posedge clk);
      rd_strobe <= 1'b0;
      @(posedge clk);
      data = rd_data;
      resp = rd_resp;
   endtask

   task automatic write_okay(input data_t addr, input data_t data);
      resp_t resp;
      reg_write(addr, data, resp);
      check_value("wr_resp", resp, resp_okay_c);
   endtask

   task automatic read_expect(input string name, input data_t addr, input data_t expected);
      data_t value;
      resp_t resp;
      reg_read(addr, value, resp);
      check_value("rd_resp", resp, resp_okay_c);
      check_value(name, value, expected);
   endtask

   // Input words then the load bit
   // Model queue gets the same item
   task automatic load_pattern(input int fifo, input logic [pattern_width-1:0] value);
      for (int w = 0; w < words_c; w++) begin
         write_okay(input_addr_c + data_t'(4 * w), value[32 * w +: 32]);
      end
      if (fifo == 0) begin
         write_okay(ctl_addr_c, data_t'(1) << bit_f0_load_c);
         q0.push_back(value);
      end else begin
         write_okay(ctl_addr_c, data_t'(1) << bit_f1_load_c);
         q1.push_back(value);
      end
   endtask

   task automatic wait_items(input int target);
      while (accepted < target) @(posedge clk);
   endtask

   // Output must stay quiet once the current frame runs out
   task automatic expect_quiet();
      while (model_active != sel_none_c) @(posedge clk);
      repeat (quiet_cycles_c) begin
         @(posedge clk);
         check_value("out_valid", out_valid, 1'b0);
      end
   endtask

   // ========================================
   // Compare process and run limit
   // ========================================
   always @(posedge clk) begin
      logic [pattern_width-1:0] expected;
      bit                       known;
      if (resetn && out_valid && out_ready) begin
         expected = predict_next_item(known);
         if (known) begin
            check_value("out_data", out_data, expected);
         end else begin
            error_count++;
            $display("Output item sent while no FIFO was started at %0t", $time);
         end
         accepted <= accepted + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles_c) begin
         $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
         $display("Checks: %0d, errors: %0d", check_count, error_count);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // ========================================
   // Stimulus
   // ========================================
   initial begin
      logic [pattern_width-1:0] words;
      data_t                    value;
      resp_t                    resp;
      int                       target;

      wr_addr   = '0;
      wr_data   = '0;
      wr_strobe = 1'b0;
      rd_addr   = '0;
      rd_strobe = 1'b0;
      out_ready = 1'b1;
      while (!resetn) @(posedge clk);
      @(posedge clk);
      check_value("out_valid", out_valid, 1'b0);
      check_value("wr_idle", wr_idle, 1'b1);
      check_value("rd_idle", rd_idle, 1'b1);

      // Input words read back
      words = random_bits(pattern_width);
      for (int w = 0; w < words_c; w++) begin
         write_okay(input_addr_c + data_t'(4 * w), words[32 * w +: 32]);
      end
      for (int w = 0; w < words_c; w++) begin
         read_expect("input_word", input_addr_c + data_t'(4 * w), words[32 * w +: 32]);
      end
      // Unmapped address answers with a decode error
      reg_write(unmapped_addr_c, data_t'(random_bits(32)), resp);
      check_value("wr_resp", resp, resp_decerr_c);
      reg_read(unmapped_addr_c, value, resp);
      check_value("rd_resp", resp, resp_decerr_c);

      // FIFO 0 with four items over three frames
      for (int i = 0; i < 4; i++) begin
         load_pattern(0, (random_bits(56) << 8) | 64'(i));
      end
      read_expect("f0_count", f0_cnt_addr_c, 32'd4);
      write_okay(start_addr_c, data_t'(sel_f0_c));
      wait_items(accepted + 12);
      read_expect("start", start_addr_c, data_t'(sel_f0_c));

      // Same stream under random back-pressure
      target = accepted + 12;
      while (accepted < target) begin
         out_ready <= (random_bits(1) != 0);
         @(posedge clk);
      end
      out_ready <= 1'b1;

      // FIFO 1 goes on deck while FIFO 0 streams
      for (int i = 0; i < 3; i++) begin
         load_pattern(1, (random_bits(56) << 8) | 64'(8'h10 + i));
      end
      write_okay(start_addr_c, data_t'(sel_f1_c));
      while (f1_items < 6) @(posedge clk);
      read_expect("start", start_addr_c, data_t'(sel_f1_c));
      read_expect("f1_count", f1_cnt_addr_c, 32'd3);

      // Clear FIFO 0
      // Clear bit visible while the write side is busy
      write_okay(ctl_addr_c, data_t'(1) << bit_f0_reset_c);
      q0.delete();
      check_value("wr_idle", wr_idle, 1'b0);
      read_expect("fifo_ctl", ctl_addr_c, 32'd1);
      read_expect("f0_count", f0_cnt_addr_c, 32'd0);

      // Start of an empty FIFO is refused
      write_okay(start_addr_c, data_t'(sel_f0_c));
      expect_quiet();
      read_expect("start", start_addr_c, data_t'(sel_none_c));

      // Both bits set is refused too
      write_okay(start_addr_c, data_t'(sel_f1_c));
      target = f1_items + 3;
      while (f1_items < target) @(posedge clk);
      write_okay(start_addr_c, 32'd3);
      expect_quiet();
      read_expect("start", start_addr_c, data_t'(sel_none_c));

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clock, active-low reset released after a fixed number of cycles
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int period_ns    = 8,
   parameter int reset_cycles = 16
) (
   output logic clk,
   output logic resetn
);

   // Half period per toggle
   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // Reset released on a rising edge, like any other stimulus
   initial begin
      resetn = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      resetn <= 1'b1;
   end

endmodule

// File: src/pattern_ctrl.sv
// Pattern generator top level
// Register handler ports in, recirculating pattern stream out
`timescale 1ns/100ps

module pattern_ctrl #(
   parameter int pattern_width = pattern_pkg::pattern_width_c,
   parameter int fifo_depth    = 16
) (
   input  logic                     clk,
   input  logic                     resetn,
   // Write handler
   input  reg_map_pkg::data_t       wr_addr,
   input  reg_map_pkg::data_t       wr_data,
   input  logic                     wr_strobe,
   output reg_map_pkg::resp_t       wr_resp,
   output logic                     wr_idle,
   // Read handler
   input  reg_map_pkg::data_t       rd_addr,
   input  logic                     rd_strobe,
   output reg_map_pkg::data_t       rd_data,
   output reg_map_pkg::resp_t       rd_resp,
   output logic                     rd_idle,
   // Output stream
   output logic [pattern_width-1:0] out_data,
   output logic                     out_valid,
   input  logic                     out_ready
);
   import pattern_pkg::*;

   fifo_sel_t                active;
   logic [pattern_width-1:0] head_data [2];
   logic [1:0]               head_valid;
   logic [1:0]               pop;

   pattern_ctl_if #(.pattern_width(pattern_width)) ctl_if ();

   // ========================================
   // Register stage
   // ========================================
   pattern_regs #(
      .pattern_width(pattern_width)
   ) regs_inst (
      .clk      (clk),
      .resetn   (resetn),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .wr_strobe(wr_strobe),
      .wr_resp  (wr_resp),
      .wr_idle  (wr_idle),
      .rd_addr  (rd_addr),
      .rd_strobe(rd_strobe),
      .rd_data  (rd_data),
      .rd_resp  (rd_resp),
      .rd_idle  (rd_idle),
      .active   (active),
      .ctl      (ctl_if)
   );

   // Two FIFO loops, each takes its own load and clear bit
   for (genvar i = 0; i < 2; i++) begin : g_loop
      pattern_loop #(
         .pattern_width(pattern_width),
         .fifo_depth   (fifo_depth)
      ) loop_inst (
         .clk       (clk),
         .resetn    (resetn),
         .load      (ctl_if.load[i]),
         .clear     (ctl_if.clear[i]),
         .pattern   (ctl_if.pattern),
         .pop       (pop[i]),
         .head_data (head_data[i]),
         .head_valid(head_valid[i])
      );
   end

   // ========================================
   // Output sequencer
   // ========================================
   pattern_sequencer #(
      .pattern_width(pattern_width)
   ) seq_inst (
      .clk        (clk),
      .resetn     (resetn),
      .ctl        (ctl_if),
      .head0_data (head_data[0]),
      .head0_valid(head_valid[0]),
      .head1_data (head_data[1]),
      .head1_valid(head_valid[1]),
      .pop0       (pop[0]),
      .pop1       (pop[1]),
      .active     (active),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

// File: src/pattern_sequencer.sv
// Output sequencer
// Streams the active FIFO frame by frame and switches at frame boundaries
`timescale 1ns/100ps

module pattern_sequencer #(
   parameter int pattern_width = pattern_pkg::pattern_width_c
) (
   input  logic                     clk,
   input  logic                     resetn,
   pattern_ctl_if.seq               ctl,
   input  logic [pattern_width-1:0] head0_data,
   input  logic                     head0_valid,
   input  logic [pattern_width-1:0] head1_data,
   input  logic                     head1_valid,
   output logic                     pop0,
   output logic                     pop1,
   output pattern_pkg::fifo_sel_t   active,
   output logic [pattern_width-1:0] out_data,
   output logic                     out_valid,
   input  logic                     out_ready
);
   import pattern_pkg::*;

   // Items left in the current frame
   count_t remaining;
   logic   accept;
   logic   frame_end;

   // Valid only when the active FIFO holds a real head item
   // A recirculating item is never sent early
   assign out_valid = (active == sel_f0_c && head0_valid) ||
                      (active == sel_f1_c && head1_valid);

   assign out_data = (active == sel_f1_c) ? head1_data :
                     (active == sel_f0_c) ? head0_data : '0;

   // Handshake on the output stream
   assign accept = out_valid && out_ready;

   // Each accepted item leaves its FIFO
   assign pop0 = accept && (active == sel_f0_c);
   assign pop1 = accept && (active == sel_f1_c);

   // Frame ends when idle or when its last item goes out
   assign frame_end = (active == sel_none_c) || (accept && remaining == count_t'(1));

   // ========================================
   // Frame FSM
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         active    <= sel_none_c;
         remaining <= '0;
      end else if (frame_end) begin
         // Pick up whatever is on deck right now
         // An emptied FIFO never starts a frame
         if (ctl.on_deck == sel_f0_c && ctl.f0_count != '0) begin
            active    <= sel_f0_c;
            remaining <= ctl.f0_count;
         end else if (ctl.on_deck == sel_f1_c && ctl.f1_count != '0) begin
            active    <= sel_f1_c;
            remaining <= ctl.f1_count;
         end else begin
            active    <= sel_none_c;
            remaining <= '0;
         end
      end else if (accept) begin
         remaining <= remaining - 1'b1;
      end
   end

   // Stalled item stays on the bus until taken
   a_hold_on_stall: assert property (@(posedge clk) disable iff (!resetn)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("output changed while stalled");

endmodule

// File: src/pattern_loop.sv
// Recirculating pattern FIFO
// Loaded from the register stage, every popped head item is written back
`timescale 1ns/100ps

module pattern_loop #(
   parameter int pattern_width = pattern_pkg::pattern_width_c,
   parameter int fifo_depth    = 16
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     load,
   input  logic                     clear,
   input  logic [pattern_width-1:0] pattern,
   input  logic                     pop,
   output logic [pattern_width-1:0] head_data,
   output logic                     head_valid
);
   localparam int ptr_w_c = $clog2(fifo_depth);

   logic                     fifo_rst;
   logic [pattern_width-1:0] in_data;
   logic                     in_valid;
   logic [pattern_width-1:0] mem [fifo_depth];
   logic [ptr_w_c:0]         wr_ptr;
   logic [ptr_w_c:0]         rd_ptr;
   logic                     full;
   logic                     empty;

   // System reset or a timed clear from software
   assign fifo_rst = !resetn || clear;

   // Extra pointer bit tells full from empty
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[ptr_w_c] != rd_ptr[ptr_w_c]) &&
                  (wr_ptr[ptr_w_c-1:0] == rd_ptr[ptr_w_c-1:0]);

   // Show-ahead head of the FIFO
   assign head_data  = mem[rd_ptr[ptr_w_c-1:0]];
   assign head_valid = !empty;

   // ========================================
   // Input selector
   // ========================================
   always_ff @(posedge clk) begin
      if (fifo_rst) begin
         in_valid <= 1'b0;
      end else begin
         in_valid <= load || pop;
      end
   end

   // Load wins over feedback
   always_ff @(posedge clk) begin
      if (load) begin
         in_data <= pattern;
      end else if (pop) begin
         in_data <= head_data;
      end
   end

   // ========================================
   // Storage and pointers
   // ========================================
   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem[wr_ptr[ptr_w_c-1:0]] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Loads beyond the depth would overwrite the pattern
   a_no_overflow: assert property (@(posedge clk) disable iff (fifo_rst)
      in_valid |-> !full)
      else $error("write into a full pattern FIFO");

   // Sequencer pops only a valid head
   a_no_underflow: assert property (@(posedge clk) disable iff (fifo_rst)
      pop |-> !empty)
      else $error("pop from an empty pattern FIFO");

endmodule

// File: src/pattern_regs.sv
// Pattern generator register stage
// Decodes handler writes and reads, keeps counts, clear timers and input words
`timescale 1ns/100ps

module pattern_regs #(
   parameter int pattern_width = pattern_pkg::pattern_width_c
) (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_map_pkg::data_t    wr_addr,
   input  reg_map_pkg::data_t    wr_data,
   input  logic                  wr_strobe,
   output reg_map_pkg::resp_t    wr_resp,
   output logic                  wr_idle,
   input  reg_map_pkg::data_t    rd_addr,
   input  logic                  rd_strobe,
   output reg_map_pkg::data_t    rd_data,
   output reg_map_pkg::resp_t    rd_resp,
   output logic                  rd_idle,
   input  pattern_pkg::fifo_sel_t active,
   pattern_ctl_if.regs           ctl
);
   import pattern_pkg::*;
   import reg_map_pkg::*;

   localparam int word_w_c  = $bits(data_t);
   localparam int words_c   = pattern_width / word_w_c;
   localparam int timer_w_c = $clog2(clear_cycles_c + 1);

   logic [4:0]           wr_idx;
   logic [4:0]           rd_idx;
   logic [4:0]           wr_word;
   logic [4:0]           rd_word;
   logic                 wr_input_hit;
   logic                 rd_input_hit;
   logic                 wr_known;
   logic                 start_ok;
   logic [timer_w_c-1:0] clear_timer [2];
   logic                 clear_wait;

   // Byte address to register index
   assign wr_idx  = 5'((wr_addr[6:0] & addr_mask_c) >> 2);
   assign rd_idx  = 5'((rd_addr[6:0] & addr_mask_c) >> 2);
   assign wr_word = wr_idx - 5'(reg_input_base_c);
   assign rd_word = rd_idx - 5'(reg_input_base_c);

   // Input words occupy a window above the base index
   assign wr_input_hit = (wr_idx >= reg_input_base_c) && (wr_idx < reg_input_base_c + words_c);
   assign rd_input_hit = (rd_idx >= reg_input_base_c) && (rd_idx < reg_input_base_c + words_c);

   // Writable registers, the counts are read-only
   assign wr_known = (wr_idx == reg_fifo_ctl_c) || (wr_idx == reg_start_c) || wr_input_hit;

   // Only a single FIFO that holds data may go on deck
   assign start_ok = (wr_data[1:0] == sel_f0_c && ctl.f0_count != '0) ||
                     (wr_data[1:0] == sel_f1_c && ctl.f1_count != '0);

   // Write side busy until both clears have finished
   assign wr_idle = !wr_strobe && !clear_wait;
   assign rd_idle = !rd_strobe;

   // FIFO held in reset while its timer runs
   assign ctl.clear[0] = (clear_timer[0] != '0);
   assign ctl.clear[1] = (clear_timer[1] != '0);

   // ========================================
   // Control state
   // ========================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ctl.load       <= '0;
         ctl.on_deck    <= sel_none_c;
         ctl.f0_count   <= '0;
         ctl.f1_count   <= '0;
         clear_timer[0] <= '0;
         clear_timer[1] <= '0;
         clear_wait     <= 1'b0;
      end else begin
         // Load strobes last one cycle
         ctl.load <= '0;

         // Timers run down to zero
         for (int i = 0; i < 2; i++) begin
            if (clear_timer[i] != '0) begin
               clear_timer[i] <= clear_timer[i] - 1'b1;
            end
         end
         if (clear_wait && clear_timer[0] == '0 && clear_timer[1] == '0) begin
            clear_wait <= 1'b0;
         end

         if (wr_strobe) begin
            case (wr_idx)
               reg_fifo_ctl_c: begin
                  // Clear first so a load in the same write still counts
                  if (wr_data[bit_f0_reset_c]) begin
                     ctl.f0_count   <= '0;
                     clear_timer[0] <= timer_w_c'(clear_cycles_c);
                     clear_wait     <= 1'b1;
                  end
                  if (wr_data[bit_f1_reset_c]) begin
                     ctl.f1_count   <= '0;
                     clear_timer[1] <= timer_w_c'(clear_cycles_c);
                     clear_wait     <= 1'b1;
                  end
                  if (wr_data[bit_f0_load_c]) begin
                     ctl.load[0]  <= 1'b1;
                     ctl.f0_count <= ctl.f0_count + 1'b1;
                  end
                  if (wr_data[bit_f1_load_c]) begin
                     ctl.load[1]  <= 1'b1;
                     ctl.f1_count <= ctl.f1_count + 1'b1;
                  end
               end
               reg_start_c: ctl.on_deck <= start_ok ? fifo_sel_t'(wr_data[1:0]) : sel_none_c;
               default: ;
            endcase
         end
      end
   end

   // ========================================
   // Input words and responses
   // ========================================
   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         wr_resp <= wr_known ? resp_okay_c : resp_decerr_c;
         if (wr_input_hit) begin
            ctl.pattern[int'(wr_word) * word_w_c +: word_w_c] <= wr_data;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_strobe) begin
         rd_resp <= resp_okay_c;
         case (rd_idx)
            reg_fifo_ctl_c: rd_data <= data_t'(ctl.clear);
            reg_start_c:    rd_data <= data_t'(active);
            reg_f0_count_c: rd_data <= data_t'(ctl.f0_count);
            reg_f1_count_c: rd_data <= data_t'(ctl.f1_count);
            default: begin
               if (rd_input_hit) begin
                  rd_data <= ctl.pattern[int'(rd_word) * word_w_c +: word_w_c];
               end else begin
                  rd_resp <= resp_decerr_c;
               end
            end
         endcase
      end
   end

   // Host must wait for idle before the next write
   a_wr_when_idle: assert property (@(posedge clk) disable iff (!resetn)
      wr_strobe |-> !clear_wait)
      else $error("write strobe while a FIFO clear is in progress");

endmodule

// File: src/pattern_ctl_if.sv
// Control bundle from the register stage to the FIFO loops and sequencer
// Load strobes, clear levels, input pattern, on-deck selection and counts
`timescale 1ns/100ps

interface pattern_ctl_if #(
   parameter int pattern_width = pattern_pkg::pattern_width_c
);
   import pattern_pkg::*;

   // One-cycle load strobes, one per FIFO
   logic [1:0]               load;
   // High while a FIFO is held in reset
   logic [1:0]               clear;
   // Assembled input words
   logic [pattern_width-1:0] pattern;
   // FIFO to stream at the next frame boundary
   fifo_sel_t                on_deck;
   // Items held in each FIFO
   count_t                   f0_count;
   count_t                   f1_count;

   // Register stage drives everything
   modport regs (output load, clear, pattern, on_deck, f0_count, f1_count);

   // FIFO side, bits picked per instance
   modport loop (input load, clear, pattern);

   // Sequencer only needs the selection and frame lengths
   modport seq (input on_deck, f0_count, f1_count);

endinterface

// File: src/reg_map_pkg.sv
// Register map of the pattern generator
// Register indices, control bits, response codes and register types
package reg_map_pkg;

   // Register word and handler response
   typedef logic [31:0] data_t;
   typedef logic [1:0]  resp_t;

   // Register indices, byte address divided by four
   localparam int reg_fifo_ctl_c   = 0;
   localparam int reg_start_c      = 1;
   localparam int reg_f0_count_c   = 2;
   localparam int reg_f1_count_c   = 3;
   // First input word, further words follow in order
   localparam int reg_input_base_c = 16;

   // FIFO control register bits
   // Reset bits read back as the clear state, load bits are write-only
   localparam int bit_f0_reset_c = 0;
   localparam int bit_f1_reset_c = 1;
   localparam int bit_f0_load_c  = 2;
   localparam int bit_f1_load_c  = 3;

   // Handler responses
   localparam resp_t resp_okay_c   = 2'd0;
   localparam resp_t resp_decerr_c = 2'd3;

   // 128 bytes of register space
   localparam logic [6:0] addr_mask_c = 7'h7F;

endpackage

// File: src/pattern_pkg.sv
// Pattern generator shared types
// Pattern and count sizes, FIFO selection encoding, clear length
package pattern_pkg;

   // Default width of one pattern item, the top level may override it
   localparam int pattern_width_c = 64;

   // Width of the item counts
   localparam int count_width_c = 16;

   // Number of items held in one FIFO
   typedef logic [count_width_c-1:0] count_t;

   // One-hot FIFO selection
   typedef logic [1:0] fifo_sel_t;

   localparam fifo_sel_t sel_none_c = 2'b00;
   localparam fifo_sel_t sel_f0_c   = 2'b01;
   localparam fifo_sel_t sel_f1_c   = 2'b10;

   // Cycles a FIFO is held in reset after a clear request
   localparam int clear_cycles_c = 7;

endpackage
